// ==== src/rgb_probe_cfg.svh ====
/*
 * Widths, opcodes and synchroniser depth for the RGB probe front end.
 * Payload lengths are in bytes and exclude the opcode byte.
 */
`ifndef RGB_PROBE_CFG_SVH
`define RGB_PROBE_CFG_SVH

// Data path widths
`define RGB_W           24
`define ROT_W           16
`define CONF_W          48
`define DEBUG_W         32

// Longest SPI frame, opcode plus six payload bytes
`define CMD_MAX_BYTES   7

// Flops per bit in the input synchronisers
`define SYNC_STAGES     2

// Write opcodes and their minimum payload length
`define OP_WR_ROT       8'h01
`define OP_WR_CONF      8'h02
`define OP_WR_EN        8'h03
`define LEN_WR_ROT      3'd2
`define LEN_WR_CONF     3'd6
`define LEN_WR_EN       3'd1

// Read opcodes
`define OP_RD_DEBUG     8'h10
`define OP_RD_ROT       8'h11
`define OP_RD_CONF      8'h12

`endif

// ==== src/rgb_probe_pkg.sv ====
/*
 * Shared types for the SPI command path.
 * Payload bytes are stored left-aligned, first received byte in the top bits.
 */
`include "rgb_probe_cfg.svh"

package rgb_probe_pkg;

    // Short write view: first two payload bytes, the rest unused
    typedef struct packed {
        logic [7:0]               first;
        logic [7:0]               second;
        logic [`CONF_W-17:0]      pad;
    } cmd_short_t;

    // One payload word, read either as a full config or as a short write
    typedef union packed {
        logic [`CONF_W-1:0]       conf;
        cmd_short_t               short_wr;
    } cmd_payload_u;

    // Complete command frame as handed to the decoder
    typedef struct packed {
        logic [7:0]               opcode;
        cmd_payload_u             payload;
        // Payload bytes received, 0 to 6
        logic [2:0]               len_bytes;
    } spi_cmd_t;

    // Read response, shifted out MSB byte first
    typedef logic [`CONF_W-1:0] spi_resp_t;

endpackage

// ==== src/sync_sig.sv ====
/*
 * Multi-flop synchroniser for a bus of independent asynchronous bits.
 * No bus coherency is implied, each bit resolves on its own.
 */
`include "rgb_probe_cfg.svh"

module sync_sig #(
    parameter int SIZE = 1
) (
    input  logic            clk,
    input  logic            nrst,
    input  logic [SIZE-1:0] in_sig,
    output logic [SIZE-1:0] out_sig
);

    // Stage 0 takes the raw input, last stage feeds the core
    logic [`SYNC_STAGES-1:0][SIZE-1:0] chain;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            chain <= '0;
        end else begin
            chain <= {chain[`SYNC_STAGES-2:0], in_sig};
        end
    end

    assign out_sig = chain[`SYNC_STAGES-1];

endmodule

// ==== src/spi_slave.sv ====
/*
 * Oversampling SPI slave, mode 0, MSB first. Inputs must already be synchronised.
 * sclk must not exceed clk/8. A partial last byte is dropped, and bytes past
 * the seventh are ignored.
 */
`include "rgb_probe_cfg.svh"

module spi_slave import rgb_probe_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  logic       sclk_s,
    input  logic       cs_n_s,
    input  logic       mosi_s,
    output logic       miso,
    output spi_cmd_t   cmd,
    output logic       cmd_valid,
    output logic [7:0] opcode,
    output logic       opcode_valid,
    input  spi_resp_t  resp
);

    // Previous samples and registered edge flags
    logic sclk_prev;
    logic cs_prev;
    logic sclk_rise;
    logic sclk_fall;
    logic cs_rise;
    logic mosi_q;

    // Receive state
    logic [2:0]   bit_cnt;
    logic [2:0]   byte_cnt;
    logic [7:0]   rx_sr;
    logic [7:0]   rx_byte;
    cmd_payload_u payload_q;

    // Transmit state
    logic         load_pending;
    spi_resp_t    tx_sr;

    // Edge detection, all flags lined up with mosi_q
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            sclk_prev <= 1'b0;
            cs_prev   <= 1'b0;
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
            cs_rise   <= 1'b0;
            mosi_q    <= 1'b0;
        end else begin
            sclk_prev <= sclk_s;
            cs_prev   <= cs_n_s;
            sclk_rise <= sclk_s & ~sclk_prev;
            sclk_fall <= ~sclk_s & sclk_prev;
            cs_rise   <= cs_n_s & ~cs_prev;
            mosi_q    <= mosi_s;
        end
    end

    // Byte completed by the current rising edge
    assign rx_byte = {rx_sr[6:0], mosi_q};

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            bit_cnt      <= '0;
            byte_cnt     <= '0;
            rx_sr        <= '0;
            payload_q    <= '0;
            opcode       <= '0;
            opcode_valid <= 1'b0;
            load_pending <= 1'b0;
            cmd          <= '0;
            cmd_valid    <= 1'b0;
        end else begin
            cmd_valid    <= 1'b0;
            load_pending <= 1'b0;
            if (cs_rise) begin
                // End of frame, commit only if the opcode byte arrived
                if (byte_cnt != 3'd0) begin
                    cmd.opcode    <= opcode;
                    cmd.payload   <= payload_q;
                    cmd.len_bytes <= byte_cnt - 3'd1;
                    cmd_valid     <= 1'b1;
                end
                bit_cnt      <= '0;
                byte_cnt     <= '0;
                opcode_valid <= 1'b0;
            end else if (cs_prev) begin
                // Deselected, hold the frame state cleared
                bit_cnt      <= '0;
                byte_cnt     <= '0;
                payload_q    <= '0;
                opcode_valid <= 1'b0;
            end else if (sclk_rise) begin
                rx_sr   <= rx_byte;
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    if (byte_cnt == 3'd0) begin
                        opcode       <= rx_byte;
                        opcode_valid <= 1'b1;
                        // Decoder sees the opcode next cycle
                        load_pending <= 1'b1;
                    end else if (byte_cnt < `CMD_MAX_BYTES) begin
                        // Byte n lands at bits 55-8n, first payload byte on top
                        payload_q.conf[(`CONF_W + 7) - 8 * int'(byte_cnt) -: 8] <= rx_byte;
                    end
                    // Saturate so extra bytes are dropped
                    if (byte_cnt < `CMD_MAX_BYTES) begin
                        byte_cnt <= byte_cnt + 3'd1;
                    end
                end
            end
        end
    end

    // Response shifter, updated on sclk falling edges after the opcode
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            miso  <= 1'b0;
            tx_sr <= '0;
        end else if (cs_prev) begin
            miso  <= 1'b0;
            tx_sr <= '0;
        end else if (load_pending) begin
            tx_sr <= resp;
        end else if (sclk_fall && byte_cnt != 3'd0) begin
            miso  <= tx_sr[`CONF_W-1];
            tx_sr <= {tx_sr[`CONF_W-2:0], 1'b0};
        end
    end

endmodule

// ==== src/spi_cmd_decoder.sv ====
/*
 * Applies SPI command frames to the driver state and serves read responses.
 * Frames shorter than the opcode needs, or with unknown opcodes, are ignored.
 */
`include "rgb_probe_cfg.svh"

module spi_cmd_decoder import rgb_probe_pkg::*; (
    input  logic                clk,
    input  logic                nrst,
    input  spi_cmd_t            cmd,
    input  logic                cmd_valid,
    input  logic [7:0]          opcode,
    input  logic                opcode_valid,
    output spi_resp_t           resp,
    input  logic [`DEBUG_W-1:0] debug_data,
    output logic [`ROT_W-1:0]   rotation_data,
    output logic [`CONF_W-1:0]  configuration,
    output logic                new_config_available,
    output logic                rgb_enable
);

    // Write path, one cycle after cmd_valid
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rotation_data        <= '0;
            configuration        <= '0;
            rgb_enable           <= 1'b0;
            new_config_available <= 1'b0;
        end else begin
            new_config_available <= 1'b0;
            if (cmd_valid) begin
                case (cmd.opcode)
                    `OP_WR_ROT: begin
                        // Rotation is the first two payload bytes
                        if (cmd.len_bytes >= `LEN_WR_ROT) begin
                            rotation_data <= {cmd.payload.short_wr.first,
                                              cmd.payload.short_wr.second};
                        end
                    end
                    `OP_WR_CONF: begin
                        if (cmd.len_bytes >= `LEN_WR_CONF) begin
                            configuration        <= cmd.payload.conf;
                            new_config_available <= 1'b1;
                        end
                    end
                    `OP_WR_EN: begin
                        // Only bit 0 of the single byte counts
                        if (cmd.len_bytes >= `LEN_WR_EN) begin
                            rgb_enable <= cmd.payload.short_wr.first[0];
                        end
                    end
                    default: begin
                        // Reads and unknown opcodes leave state alone
                    end
                endcase
            end
        end
    end

    // Read path, left-aligned in the response word
    always_comb begin
        resp = '0;
        if (opcode_valid) begin
            case (opcode)
                `OP_RD_DEBUG: resp = {debug_data, {(`CONF_W - `DEBUG_W){1'b0}}};
                `OP_RD_ROT:   resp = {rotation_data, {(`CONF_W - `ROT_W){1'b0}}};
                `OP_RD_CONF:  resp = configuration;
                default:      resp = '0;
            endcase
        end
    end

endmodule

// ==== src/rgb_frame_probe.sv ====
/*
 * Captures the first pixel of each frame and counts frames while enabled.
 * Frame start is hsync and vsync rising in the same cycle, inputs synchronised.
 */
`include "rgb_probe_cfg.svh"

module rgb_frame_probe (
    input  logic                clk,
    input  logic                nrst,
    input  logic                hsync,
    input  logic                vsync,
    input  logic [`RGB_W-1:0]   data,
    input  logic                enable,
    output logic [`DEBUG_W-1:0] debug_data
);

    logic                         hsync_prev;
    logic                         vsync_prev;
    logic                         start_q;
    // Pixel delayed to line up with start_q
    logic [`RGB_W-1:0]            pixel_q;
    logic [`DEBUG_W-`RGB_W-1:0]   frame_cnt;
    logic [`RGB_W-1:0]            first_pixel;

    // Edge detect stage
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            hsync_prev <= 1'b0;
            vsync_prev <= 1'b0;
            start_q    <= 1'b0;
            pixel_q    <= '0;
        end else begin
            hsync_prev <= hsync;
            vsync_prev <= vsync;
            start_q    <= hsync & ~hsync_prev & vsync & ~vsync_prev;
            pixel_q    <= data;
        end
    end

    // Capture stage, count wraps at 255
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            frame_cnt   <= '0;
            first_pixel <= '0;
        end else if (start_q && enable) begin
            frame_cnt   <= frame_cnt + 1'b1;
            first_pixel <= pixel_q;
        end
    end

    assign debug_data = {frame_cnt, first_pixel};

endmodule

// ==== src/rgb_probe_top.sv ====
/*
 * Debug front end top. nrst doubles as the clock-ready signal.
 * All pins are asynchronous to clk and pass through synchronisers.
 */
`include "rgb_probe_cfg.svh"

module rgb_probe_top import rgb_probe_pkg::*; (
    input  logic               clk,
    input  logic               nrst,
    input  logic               rgb_hsync,
    input  logic               rgb_vsync,
    input  logic [`RGB_W-1:0]  rgb_d,
    input  logic               spi_sclk,
    input  logic               spi_cs,
    input  logic               spi_mosi,
    output logic               spi_miso,
    output logic [`ROT_W-1:0]  rotation_data,
    output logic [`CONF_W-1:0] driver_conf,
    output logic               new_config_available,
    output logic               rgb_enable
);

    // Synchronised video inputs
    logic               hsync_s;
    logic               vsync_s;
    logic [`RGB_W-1:0]  data_s;

    // Synchronised SPI lines
    logic               sclk_s;
    logic               cs_n_s;
    logic               mosi_s;

    // Slave to decoder
    spi_cmd_t           cmd;
    logic               cmd_valid;
    logic [7:0]         opcode;
    logic               opcode_valid;
    spi_resp_t          resp;

    logic [`DEBUG_W-1:0] debug_data;

    sync_sig #(.SIZE(`RGB_W + 2)) sync_rgb_inst (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  ({rgb_hsync, rgb_vsync, rgb_d}),
        .out_sig ({hsync_s, vsync_s, data_s})
    );

    sync_sig #(.SIZE(3)) sync_spi_inst (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  ({spi_sclk, spi_cs, spi_mosi}),
        .out_sig ({sclk_s, cs_n_s, mosi_s})
    );

    rgb_frame_probe rgb_frame_probe_inst (
        .clk        (clk),
        .nrst       (nrst),
        .hsync      (hsync_s),
        .vsync      (vsync_s),
        .data       (data_s),
        .enable     (rgb_enable),
        .debug_data (debug_data)
    );

    spi_slave spi_slave_inst (
        .clk          (clk),
        .nrst         (nrst),
        .sclk_s       (sclk_s),
        .cs_n_s       (cs_n_s),
        .mosi_s       (mosi_s),
        .miso         (spi_miso),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .opcode       (opcode),
        .opcode_valid (opcode_valid),
        .resp         (resp)
    );

    spi_cmd_decoder spi_cmd_decoder_inst (
        .clk                  (clk),
        .nrst                 (nrst),
        .cmd                  (cmd),
        .cmd_valid            (cmd_valid),
        .opcode               (opcode),
        .opcode_valid         (opcode_valid),
        .resp                 (resp),
        .debug_data           (debug_data),
        .rotation_data        (rotation_data),
        .configuration        (driver_conf),
        .new_config_available (new_config_available),
        .rgb_enable           (rgb_enable)
    );

endmodule

// ==== test/rgb_probe_tb.sv ====
/*
 * Testbench for the RGB probe front end, steps read from test/rgb_probe_input.txt.
 * Run from the project root so the step file is found. SPI host runs at clk/10.
 */
`include "rgb_probe_cfg.svh"

module rgb_probe_tb;

    localparam int MAX_STEPS = 64;
    // Clock cycles per sclk phase
    localparam int HALF_SCLK = 5;

    typedef logic [8*24-1:0] name_t;

    logic                clk = 1'b0;
    logic                nrst;
    logic                rgb_hsync;
    logic                rgb_vsync;
    logic [`RGB_W-1:0]   rgb_d;
    logic                spi_sclk;
    logic                spi_cs;
    logic                spi_mosi;
    logic                spi_miso;
    logic [`ROT_W-1:0]   rotation_data;
    logic [`CONF_W-1:0]  driver_conf;
    logic                new_config_available;
    logic                rgb_enable;

    // Step table from the input file
    logic [7:0]          step_kind [MAX_STEPS];
    name_t               step_name [MAX_STEPS];
    logic [7:0]          step_op   [MAX_STEPS];
    logic [7:0]          step_cnt  [MAX_STEPS];
    logic [`CONF_W-1:0]  step_val  [MAX_STEPS];
    int                  n_steps = 0;
    logic                loaded = 1'b0;

    int                  err_cnt = 0;
    int                  check_cnt = 0;
    int                  pulse_cnt = 0;
    integer              seed = 32'h099aac6c;

    always #20 clk = ~clk;

    rgb_probe_top rgb_probe_top_inst (
        .clk                  (clk),
        .nrst                 (nrst),
        .rgb_hsync            (rgb_hsync),
        .rgb_vsync            (rgb_vsync),
        .rgb_d                (rgb_d),
        .spi_sclk             (spi_sclk),
        .spi_cs               (spi_cs),
        .spi_mosi             (spi_mosi),
        .spi_miso             (spi_miso),
        .rotation_data        (rotation_data),
        .driver_conf          (driver_conf),
        .new_config_available (new_config_available),
        .rgb_enable           (rgb_enable)
    );

    // Config update pulses seen so far
    always @(posedge clk) begin
        if (new_config_available) begin
            pulse_cnt <= pulse_cnt + 1;
        end
    end

    task automatic check(input name_t name, input logic [`CONF_W-1:0] expected,
                         input logic [`CONF_W-1:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            err_cnt++;
            $display("MISMATCH %0s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic load_steps();
        int                 fd;
        int                 ret;
        logic [8*160-1:0]   line;
        logic [7:0]         kind;
        name_t              name;
        logic [7:0]         op;
        logic [7:0]         cnt;
        logic [`CONF_W-1:0] val;
        fd = $fopen("test/rgb_probe_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the step file test/rgb_probe_input.txt");
            err_cnt++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                ret = $fgets(line, fd);
                ret = $sscanf(line, "%s %s %h %h %h", kind, name, op, cnt, val);
                // Comment lines start with a hash
                if (ret == 5 && kind != "#") begin
                    if (n_steps < MAX_STEPS) begin
                        step_kind[n_steps] = kind;
                        step_name[n_steps] = name;
                        step_op[n_steps]   = op;
                        step_cnt[n_steps]  = cnt;
                        step_val[n_steps]  = val;
                        n_steps++;
                    end else begin
                        $display("Too many steps in the step file, extra lines ignored");
                        err_cnt++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Mode 0 host, opcode first then payload, MSB first
    task automatic spi_xfer(input logic [7:0] op, input int nbits,
                            input logic [`CONF_W-1:0] payload,
                            output logic [`CONF_W-1:0] rx);
        logic [`CONF_W+7:0] frame;
        frame = {op, payload};
        rx = '0;
        spi_cs = 1'b0;
        repeat (HALF_SCLK) @(negedge clk);
        for (int i = 0; i < nbits; i++) begin
            spi_mosi = frame[`CONF_W+7];
            frame = {frame[`CONF_W+6:0], 1'b0};
            repeat (HALF_SCLK) @(negedge clk);
            // Response bits only follow the opcode byte
            if (i >= 8) begin
                rx = {rx[`CONF_W-2:0], spi_miso};
            end
            spi_sclk = 1'b1;
            repeat (HALF_SCLK) @(negedge clk);
            spi_sclk = 1'b0;
        end
        repeat (HALF_SCLK) @(negedge clk);
        spi_cs = 1'b1;
        spi_mosi = 1'b0;
        // Covers sync, edge detect and decoder update
        repeat (12) @(negedge clk);
    endtask

    // Frame start is both syncs rising together
    task automatic rgb_frame(input logic [`RGB_W-1:0] pixel);
        rgb_d = pixel;
        rgb_hsync = 1'b1;
        rgb_vsync = 1'b1;
        repeat (10) @(negedge clk);
        rgb_hsync = 1'b0;
        rgb_vsync = 1'b0;
        rgb_d = ~pixel;
        repeat (4) @(negedge clk);
    endtask

    task automatic run_step(input int i);
        logic [`CONF_W-1:0] rx;
        logic [`CONF_W-1:0] pad;
        case (step_kind[i])
            "W": spi_xfer(step_op[i], 8 + 8 * int'(step_cnt[i]), step_val[i], rx);
            "R": begin
                // Host sends don't-care bytes while the response comes back
                pad = `CONF_W'({$random(seed), $random(seed)});
                spi_xfer(step_op[i], 8 + 8 * int'(step_cnt[i]), pad, rx);
                check(step_name[i], step_val[i], rx);
            end
            "F": rgb_frame(step_val[i][`RGB_W-1:0]);
            // Count column is a bit count here
            "B": spi_xfer(step_op[i], int'(step_cnt[i]), '0, rx);
            "P": begin
                case (step_name[i])
                    name_t'("rotation_data"):
                        check(step_name[i], step_val[i], `CONF_W'(rotation_data));
                    name_t'("driver_conf"):
                        check(step_name[i], step_val[i], driver_conf);
                    name_t'("rgb_enable"):
                        check(step_name[i], step_val[i], `CONF_W'(rgb_enable));
                    name_t'("conf_pulses"):
                        check(step_name[i], step_val[i], `CONF_W'(pulse_cnt));
                    default: begin
                        $display("Step %0d names an unknown port %0s", i, step_name[i]);
                        err_cnt++;
                    end
                endcase
            end
            default: begin
                $display("Step %0d has an unknown step type", i);
                err_cnt++;
            end
        endcase
    endtask

    initial begin
        nrst = 1'b0;
        rgb_hsync = 1'b0;
        rgb_vsync = 1'b0;
        rgb_d = '0;
        spi_sclk = 1'b0;
        spi_cs = 1'b1;
        spi_mosi = 1'b0;
        load_steps();
        loaded = 1'b1;
        repeat (8) @(negedge clk);
        nrst = 1'b1;
        repeat (4) @(negedge clk);
        for (int i = 0; i < n_steps; i++) begin
            run_step(i);
        end
        $display("Steps: %0d, checks: %0d, errors: %0d", n_steps, check_cnt, err_cnt);
        if (err_cnt == 0 && check_cnt > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog, limit scales with the number of steps
    initial begin
        int limit;
        wait (loaded);
        limit = n_steps * 2000 + 1000;
        repeat (limit) @(posedge clk);
        $display("Timeout, the steps did not finish within %0d clock periods", limit);
        $display("Steps: %0d, checks: %0d, errors: %0d", n_steps, check_cnt, err_cnt);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== test/rgb_probe_input.txt ====
# kind name opcode count value, numbers in hex
# W write (count = payload bytes), R read (count = response bytes), F frame (value = pixel)
# B partial frame (count = bits sent), P port check (name = port, value = expected)
P rotation_data 00 0 0
P driver_conf 00 0 0
P rgb_enable 00 0 0
R rd_debug_reset 10 4 0
W wr_rot 01 2 5a3c00000000
P rotation_data 00 0 5a3c
R rd_rot 11 2 5a3c
W wr_conf 02 6 123456789abc
P driver_conf 00 0 123456789abc
R rd_conf 12 6 123456789abc
P conf_pulses 00 0 1
F frame_disabled 00 0 a1b2c3
R rd_debug_disabled 10 4 0
W wr_en_on 03 1 010000000000
P rgb_enable 00 0 1
F frame_1 00 0 112233
R rd_debug_frame1 10 4 01112233
F frame_2 00 0 445566
F frame_3 00 0 778899
F frame_4 00 0 ddeeff
R rd_debug_frame4 10 4 04ddeeff
W wr_en_off 03 1 000000000000
P rgb_enable 00 0 0
F frame_held 00 0 cafe01
R rd_debug_held 10 4 04ddeeff
W wr_conf_short 02 3 ffeedd000000
W wr_rot_short 01 1 990000000000
W wr_unknown 7f 6 010203040506
B partial_rot 01 5 0
P driver_conf 00 0 123456789abc
P rotation_data 00 0 5a3c
P rgb_enable 00 0 0
P conf_pulses 00 0 1
R rd_conf_after 12 6 123456789abc
R rd_debug_after 10 4 04ddeeff

// ==== sources.f ====
+incdir+src
src/rgb_probe_pkg.sv
src/sync_sig.sv
src/spi_slave.sv
src/spi_cmd_decoder.sv
src/rgb_frame_probe.sv
src/rgb_probe_top.sv
test/rgb_probe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f sources.f --top-module rgb_probe_tb \
    -o rgb_probe_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/rgb_probe_sim > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log
grep -q "^SIMULATION PASSED$" sim.log && echo "Result: pass" \
    || { echo "Result: fail"; exit 1; }
